// File: alloc_pkg.sv
package alloc_pkg;

    // ----------------------------------------
    // Field widths
    // ----------------------------------------
    localparam int PTR_WID  = 6;
    localparam int SIZE_WID = 8;
    localparam int META_WID = 4;

    typedef logic [PTR_WID-1:0] ptr_t;

    // Descriptor as stored in the descriptor memory
    typedef struct packed {
        ptr_t                nxt_ptr;
        logic                eof;
        logic [SIZE_WID-1:0] size;
        logic [META_WID-1:0] meta;
        logic                err;
    } desc_t;

    // One gathered buffer, handed back to a context
    typedef struct packed {
        ptr_t                ptr;
        logic                eof;
        logic [SIZE_WID-1:0] size;
        logic [META_WID-1:0] meta;
        logic                err;
    } gather_resp_t;

endpackage : alloc_pkg

// File: desc_mem_pkg.sv
package desc_mem_pkg;

    // ----------------------------------------
    // Descriptor memory access
    // ----------------------------------------

    // Cycles from an accepted read to rd_ack
    localparam int DESC_RD_LAT = 1;

    // External write into the descriptor RAM
    typedef struct packed {
        alloc_pkg::ptr_t  ptr;
        alloc_pkg::desc_t desc;
    } desc_wr_t;

endpackage : desc_mem_pkg

// File: fifo_ctxt.sv
`timescale 1ns/1ps

module fifo_ctxt #(
    parameter type DATA_T = logic,
    parameter int  DEPTH  = 8
) (
    input  logic  clk,
    input  logic  srst,
    input  logic  wr,
    input  DATA_T wr_data,
    output logic  wr_rdy,
    input  logic  rd,
    output logic  rd_vld,
    output DATA_T rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    DATA_T            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Explicit wrap since DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] incr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr_rdy  = (count < CNT_W'(DEPTH));
    assign rd_vld  = (count != '0);
    assign push    = wr && wr_rdy;
    assign pop     = rd && rd_vld;
    // Show-ahead output
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= incr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= incr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule : fifo_ctxt

// File: arb_rr.sv
`timescale 1ns/1ps

module arb_rr #(
    parameter int CONTEXTS = 4
) (
    input  logic                        clk,
    input  logic                        srst,
    input  logic                        en,
    input  logic [CONTEXTS-1:0]         req,
    output logic [CONTEXTS-1:0]         grant,
    output logic [$clog2(CONTEXTS)-1:0] sel
);

    localparam int SEL_WID = $clog2(CONTEXTS);

    logic [SEL_WID-1:0] prio;
    logic               found;

    // Search from the priority pointer, wrapping once around
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = prio;
        for (int i = 0; i < CONTEXTS; i++) begin
            idx = int'(prio) + i;
            if (idx >= CONTEXTS) begin
                idx = idx - CONTEXTS;
            end
            if (!found && req[idx]) begin
                found = 1'b1;
                sel   = SEL_WID'(idx);
            end
        end
    end

    assign grant = (en && found) ? (CONTEXTS'(1) << sel) : '0;

    // Next search starts one past the winner
    always_ff @(posedge clk) begin
        if (srst) begin
            prio <= '0;
        end else if (en && found) begin
            prio <= (sel == SEL_WID'(CONTEXTS - 1)) ? '0 : sel + 1'b1;
        end
    end

endmodule : arb_rr

// File: desc_mem.sv
`timescale 1ns/1ps

module desc_mem (
    input  logic                   clk,
    input  logic                   srst,
    input  logic                   desc_wr,
    input  desc_mem_pkg::desc_wr_t desc_wr_data,
    input  logic                   rd_req,
    input  alloc_pkg::ptr_t        rd_addr,
    output logic                   rd_rdy,
    output logic                   rd_ack,
    output alloc_pkg::desc_t       rd_data,
    output logic                   init_done
);

    import alloc_pkg::*;
    import desc_mem_pkg::*;

    desc_t                  mem [2**PTR_WID];
    ptr_t                   init_addr;
    logic [DESC_RD_LAT-1:0] ack_pipe;
    desc_t                  data_pipe [DESC_RD_LAT];

    // ----------------------------------------
    // Init sweep
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            init_addr <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            init_addr <= init_addr + 1'b1;
            if (init_addr == '1) begin
                init_done <= 1'b1;
            end
        end
    end

    // Sweep wins over external writes
    always_ff @(posedge clk) begin
        if (!init_done) begin
            mem[init_addr] <= '{nxt_ptr: '0, eof: 1'b1, size: '0, meta: '0, err: 1'b0};
        end else if (desc_wr) begin
            mem[desc_wr_data.ptr] <= desc_wr_data.desc;
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------
    assign rd_rdy = init_done;

    always_ff @(posedge clk) begin
        if (srst) begin
            ack_pipe <= '0;
        end else begin
            ack_pipe <= DESC_RD_LAT'({ack_pipe, rd_req && rd_rdy});
        end
    end

    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[rd_addr];
        for (int i = 1; i < DESC_RD_LAT; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign rd_ack  = ack_pipe[DESC_RD_LAT-1];
    assign rd_data = data_pipe[DESC_RD_LAT-1];

endmodule : desc_mem

// File: alloc_gather_core.sv
`timescale 1ns/1ps

module alloc_gather_core #(
    parameter int CONTEXTS = 4,
    parameter int Q_DEPTH  = 8
) (
    input  logic                                   clk,
    input  logic                                   srst,
    input  logic                                   en,
    input  logic [CONTEXTS-1:0]                    gather_req,
    input  alloc_pkg::ptr_t [CONTEXTS-1:0]         gather_ptr,
    output logic [CONTEXTS-1:0]                    gather_rdy,
    output logic [CONTEXTS-1:0]                    gather_vld,
    output alloc_pkg::gather_resp_t [CONTEXTS-1:0] gather_resp,
    input  logic [CONTEXTS-1:0]                    gather_ack,
    output logic                                   dealloc_req,
    input  logic                                   dealloc_rdy,
    output alloc_pkg::ptr_t                        dealloc_ptr,
    output logic                                   rd_req,
    input  logic                                   rd_rdy,
    output alloc_pkg::ptr_t                        rd_addr,
    input  logic                                   rd_ack,
    input  alloc_pkg::desc_t                       rd_data,
    input  logic                                   init_done
);

    import alloc_pkg::*;

    localparam int CTXT_SEL_WID  = $clog2(CONTEXTS);
    localparam int DEALLOC_DEPTH = 8;

    typedef enum logic [1:0] {
        RESET,
        DISABLED,
        IDLE,
        READ
    } state_t;

    // Which context a read in flight belongs to
    typedef struct packed {
        ptr_t                    ptr;
        logic [CTXT_SEL_WID-1:0] id;
    } rd_ctxt_t;

    logic [CONTEXTS-1:0]     pend;
    ptr_t                    cur_ptr [CONTEXTS];
    logic [CONTEXTS-1:0]     grant;
    logic [CTXT_SEL_WID-1:0] sel;
    logic                    arb;
    state_t                  state;
    state_t                  nxt_state;
    rd_ctxt_t                rd_ctxt_in;
    rd_ctxt_t                rd_ctxt_out;
    logic                    rd_ctxt_vld;

    // ----------------------------------------
    // Per-context chain state
    // ----------------------------------------
    for (genvar g = 0; g < CONTEXTS; g++) begin : g_ctxt
        logic         accept;
        logic         rd_done;
        logic         busy_r;
        logic         pend_r;
        ptr_t         ptr_r;
        gather_resp_t resp_in;

        assign accept  = gather_req[g] && !busy_r;
        assign rd_done = rd_ack && rd_ctxt_vld && (rd_ctxt_out.id == CTXT_SEL_WID'(g));

        // Busy until the eof descriptor comes back
        always_ff @(posedge clk) begin
            if (srst) begin
                busy_r <= 1'b0;
            end else if (accept) begin
                busy_r <= 1'b1;
            end else if (rd_done && rd_data.eof) begin
                busy_r <= 1'b0;
            end
        end

        // Another read wanted; dropped once granted
        always_ff @(posedge clk) begin
            if (srst) begin
                pend_r <= 1'b0;
            end else if (accept || (rd_done && !rd_data.eof)) begin
                pend_r <= 1'b1;
            end else if (grant[g]) begin
                pend_r <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (accept) begin
                ptr_r <= gather_ptr[g];
            end else if (rd_done) begin
                ptr_r <= rd_data.nxt_ptr;
            end
        end

        assign pend[g]       = pend_r;
        assign cur_ptr[g]    = ptr_r;
        assign gather_rdy[g] = !busy_r;

        assign resp_in = '{
            ptr:  rd_ctxt_out.ptr,
            eof:  rd_data.eof,
            size: rd_data.size,
            meta: rd_data.meta,
            err:  rd_data.err
        };

        fifo_ctxt #(
            .DATA_T ( gather_resp_t ),
            .DEPTH  ( Q_DEPTH )
        ) i_fifo_resp (
            .clk,
            .srst,
            .wr      ( rd_done ),
            .wr_data ( resp_in ),
            .wr_rdy  ( ),
            .rd      ( gather_ack[g] ),
            .rd_vld  ( gather_vld[g] ),
            .rd_data ( gather_resp[g] )
        );
    end : g_ctxt

    // ----------------------------------------
    // Read FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= RESET;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        arb       = 1'b0;
        rd_req    = 1'b0;
        case (state)
            RESET: begin
                if (init_done) begin
                    nxt_state = en ? IDLE : DISABLED;
                end
            end
            DISABLED: begin
                if (en) begin
                    nxt_state = IDLE;
                end
            end
            IDLE: begin
                arb = en;
                if (!en) begin
                    nxt_state = DISABLED;
                end else if (|pend) begin
                    nxt_state = READ;
                end
            end
            READ: begin
                // Held until the memory takes it, even if en drops
                rd_req = 1'b1;
                if (rd_rdy) begin
                    nxt_state = IDLE;
                end
            end
            default: begin
                nxt_state = RESET;
            end
        endcase
    end

    arb_rr #(
        .CONTEXTS ( CONTEXTS )
    ) i_arb_rr (
        .clk,
        .srst,
        .en    ( arb ),
        .req   ( pend ),
        .grant ( grant ),
        .sel   ( sel )
    );

    // Winner's pointer, presented to the memory in READ
    always_ff @(posedge clk) begin
        if (arb && |pend) begin
            rd_ctxt_in.ptr <= cur_ptr[sel];
            rd_ctxt_in.id  <= sel;
        end
    end

    assign rd_addr = rd_ctxt_in.ptr;

    fifo_ctxt #(
        .DATA_T ( rd_ctxt_t ),
        .DEPTH  ( CONTEXTS )
    ) i_fifo_rd_ctxt (
        .clk,
        .srst,
        .wr      ( rd_req && rd_rdy ),
        .wr_data ( rd_ctxt_in ),
        .wr_rdy  ( ),
        .rd      ( rd_ack ),
        .rd_vld  ( rd_ctxt_vld ),
        .rd_data ( rd_ctxt_out )
    );

    // ----------------------------------------
    // Deallocation queue
    // ----------------------------------------
    fifo_ctxt #(
        .DATA_T ( ptr_t ),
        .DEPTH  ( DEALLOC_DEPTH )
    ) i_fifo_dealloc (
        .clk,
        .srst,
        .wr      ( rd_ack && rd_ctxt_vld ),
        .wr_data ( rd_ctxt_out.ptr ),
        .wr_rdy  ( ),
        .rd      ( dealloc_rdy ),
        .rd_vld  ( dealloc_req ),
        .rd_data ( dealloc_ptr )
    );

endmodule : alloc_gather_core

// File: alloc_gather_top.sv
`timescale 1ns/1ps

module alloc_gather_top #(
    parameter int CONTEXTS = 4,
    parameter int Q_DEPTH  = 8
) (
    input  logic                                   clk,
    input  logic                                   srst,
    input  logic                                   en,
    input  logic [CONTEXTS-1:0]                    gather_req,
    input  alloc_pkg::ptr_t [CONTEXTS-1:0]         gather_ptr,
    output logic [CONTEXTS-1:0]                    gather_rdy,
    output logic [CONTEXTS-1:0]                    gather_vld,
    output alloc_pkg::gather_resp_t [CONTEXTS-1:0] gather_resp,
    input  logic [CONTEXTS-1:0]                    gather_ack,
    output logic                                   dealloc_req,
    input  logic                                   dealloc_rdy,
    output alloc_pkg::ptr_t                        dealloc_ptr,
    input  logic                                   desc_wr,
    input  desc_mem_pkg::desc_wr_t                 desc_wr_data
);

    import alloc_pkg::*;

    // Core to descriptor memory
    logic  rd_req;
    logic  rd_rdy;
    ptr_t  rd_addr;
    logic  rd_ack;
    desc_t rd_data;
    logic  init_done;

    alloc_gather_core #(
        .CONTEXTS ( CONTEXTS ),
        .Q_DEPTH  ( Q_DEPTH )
    ) i_alloc_gather_core (
        .clk,
        .srst,
        .en,
        .gather_req,
        .gather_ptr,
        .gather_rdy,
        .gather_vld,
        .gather_resp,
        .gather_ack,
        .dealloc_req,
        .dealloc_rdy,
        .dealloc_ptr,
        .rd_req,
        .rd_rdy,
        .rd_addr,
        .rd_ack,
        .rd_data,
        .init_done
    );

    desc_mem i_desc_mem (
        .clk,
        .srst,
        .desc_wr,
        .desc_wr_data,
        .rd_req,
        .rd_addr,
        .rd_rdy,
        .rd_ack,
        .rd_data,
        .init_done
    );

endmodule : alloc_gather_top

// File: tb_alloc_gather_assertions.sv
`timescale 1ns/1ps

module tb_alloc_gather_assertions #(
    parameter int CONTEXTS = 4
) (
    input logic                clk,
    input logic                srst,
    input logic [CONTEXTS-1:0] gather_req,
    input logic [CONTEXTS-1:0] gather_rdy,
    input logic [CONTEXTS-1:0] gather_vld,
    input logic                dealloc_req,
    input logic                rd_req,
    input logic                rd_rdy,
    input logic                rd_ack,
    input alloc_pkg::desc_t    rd_data
);

    import desc_mem_pkg::*;

    int fail_cnt = 0;

    // Outputs quiet right after reset
    a_quiet_after_reset: assert property (
        @(posedge clk) srst |=> (gather_vld == '0) && !dealloc_req
    ) else begin
        $error("gather_vld or dealloc_req high in the cycle after reset");
        fail_cnt++;
    end

    // ----------------------------------------
    // Descriptor memory read timing
    // ----------------------------------------
    a_rd_ack: assert property (
        @(posedge clk) disable iff (srst) (rd_req && rd_rdy) |-> ##DESC_RD_LAT rd_ack
    ) else begin
        $error("rd_ack missing after an accepted read");
        fail_cnt++;
    end

    a_no_stray_ack: assert property (
        @(posedge clk) disable iff (srst) rd_ack |-> $past(rd_req && rd_rdy, DESC_RD_LAT)
    ) else begin
        $error("rd_ack without an accepted read");
        fail_cnt++;
    end

    for (genvar g = 0; g < CONTEXTS; g++) begin : g_ctxt
        a_rdy_low_after_accept: assert property (
            @(posedge clk) disable iff (srst) (gather_req[g] && gather_rdy[g]) |=> !gather_rdy[g]
        ) else begin
            $error("gather_rdy high right after acceptance");
            fail_cnt++;
        end

        // Ready can only return after an eof descriptor came back
        a_rdy_held_low: assert property (
            @(posedge clk) disable iff (srst)
            (!gather_rdy[g] && !(rd_ack && rd_data.eof)) |=> !gather_rdy[g]
        ) else begin
            $error("gather_rdy rose while the chain was in progress");
            fail_cnt++;
        end
    end : g_ctxt

endmodule : tb_alloc_gather_assertions

// File: tb_alloc_gather.sv
`timescale 1ns/1ps

module tb_alloc_gather;

    import alloc_pkg::*;
    import desc_mem_pkg::*;

    localparam int CONTEXTS     = 4;
    localparam int Q_DEPTH      = 8;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int INIT_CYCLES  = 2**PTR_WID + 4;
    localparam int WAIT_LIMIT   = 300;
    localparam int TEST_CYCLES  = 2 * WAIT_LIMIT + 100;
    localparam int NUM_TESTS    = 6;
    localparam int WATCHDOG_NS  =
        (RESET_CYCLES + INIT_CYCLES + NUM_TESTS * TEST_CYCLES) * CLK_PERIOD;
    localparam int MAX_RESP     = 16;
    localparam int NUM_PTRS     = 2**PTR_WID;

    logic                         clk;
    logic                         srst;
    logic                         en;
    logic [CONTEXTS-1:0]          gather_req;
    ptr_t [CONTEXTS-1:0]          gather_ptr;
    logic [CONTEXTS-1:0]          gather_rdy;
    logic [CONTEXTS-1:0]          gather_vld;
    gather_resp_t [CONTEXTS-1:0]  gather_resp;
    logic [CONTEXTS-1:0]          gather_ack;
    logic                         dealloc_req;
    logic                         dealloc_rdy;
    ptr_t                         dealloc_ptr;
    logic                         desc_wr;
    desc_wr_t                     desc_wr_data;

    // Reference model and collected outputs
    gather_resp_t exp_resp [CONTEXTS][MAX_RESP];
    int           exp_cnt [CONTEXTS];
    gather_resp_t got_resp [CONTEXTS][MAX_RESP];
    int           got_cnt [CONTEXTS];
    ptr_t         exp_dealloc [NUM_PTRS];
    int           exp_dealloc_cnt;
    ptr_t         got_dealloc [NUM_PTRS];
    int           got_dealloc_cnt;
    ptr_t         head_ptr [CONTEXTS];
    int           alloc_idx;
    logic [31:0]  rng_state;
    int           err_cnt;
    int           chk_cnt;

    alloc_gather_top #(
        .CONTEXTS ( CONTEXTS ),
        .Q_DEPTH  ( Q_DEPTH )
    ) UUT (
        .clk,
        .srst,
        .en,
        .gather_req,
        .gather_ptr,
        .gather_rdy,
        .gather_vld,
        .gather_resp,
        .gather_ack,
        .dealloc_req,
        .dealloc_rdy,
        .dealloc_ptr,
        .desc_wr,
        .desc_wr_data
    );

    bind alloc_gather_core tb_alloc_gather_assertions #(
        .CONTEXTS ( CONTEXTS )
    ) i_assertions (
        .clk,
        .srst,
        .gather_req,
        .gather_rdy,
        .gather_vld,
        .dealloc_req,
        .rd_req,
        .rd_rdy,
        .rd_ack,
        .rd_data
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Record every completed handshake
    always @(posedge clk) begin
        if (!srst) begin
            for (int c = 0; c < CONTEXTS; c++) begin
                if (gather_vld[c] && gather_ack[c] && got_cnt[c] < MAX_RESP) begin
                    got_resp[c][got_cnt[c]] = gather_resp[c];
                    got_cnt[c]++;
                end
            end
            if (dealloc_req && dealloc_rdy && got_dealloc_cnt < NUM_PTRS) begin
                got_dealloc[got_dealloc_cnt] = dealloc_ptr;
                got_dealloc_cnt++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Odd stride spreads chains over the whole memory
    function automatic ptr_t scatter_ptr(input int idx);
        return PTR_WID'(idx * 37 + 5);
    endfunction

    function automatic bit all_arrived();
        bit done;
        done = (got_dealloc_cnt >= exp_dealloc_cnt);
        for (int c = 0; c < CONTEXTS; c++) begin
            if (got_cnt[c] < exp_cnt[c]) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    task automatic flag_mismatch(input string msg);
        err_cnt++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic clear_model();
        for (int c = 0; c < CONTEXTS; c++) begin
            exp_cnt[c] = 0;
            got_cnt[c] = 0;
        end
        exp_dealloc_cnt = 0;
        got_dealloc_cnt = 0;
    endtask

    // Write a linked chain and append it to the expected results
    task automatic build_chain(input int ctx, input int len);
        ptr_t  cur;
        ptr_t  nxt;
        desc_t desc;
        cur = scatter_ptr(alloc_idx);
        head_ptr[ctx] = cur;
        for (int i = 0; i < len; i++) begin
            alloc_idx++;
            nxt = scatter_ptr(alloc_idx);
            rng_state = xorshift32(rng_state);
            desc.nxt_ptr = nxt;
            desc.eof     = (i == len - 1);
            desc.size    = SIZE_WID'(rng_state);
            desc.meta    = META_WID'(rng_state >> 8);
            desc.err     = rng_state[16];
            @(negedge clk);
            desc_wr           = 1'b1;
            desc_wr_data.ptr  = cur;
            desc_wr_data.desc = desc;
            exp_resp[ctx][exp_cnt[ctx]] = '{
                ptr:  cur,
                eof:  desc.eof,
                size: desc.size,
                meta: desc.meta,
                err:  desc.err
            };
            exp_cnt[ctx]++;
            exp_dealloc[exp_dealloc_cnt] = cur;
            exp_dealloc_cnt++;
            cur = nxt;
        end
        @(negedge clk);
        desc_wr = 1'b0;
    endtask

    // One-cycle request on every context in mask
    task automatic request_gather(input logic [CONTEXTS-1:0] mask);
        @(negedge clk);
        for (int c = 0; c < CONTEXTS; c++) begin
            if (mask[c]) begin
                gather_ptr[c] = head_ptr[c];
                chk_cnt++;
                if (!gather_rdy[c]) begin
                    flag_mismatch($sformatf("context %0d not ready for a new chain", c));
                end
            end
        end
        gather_req = mask;
        @(negedge clk);
        gather_req = '0;
        chk_cnt++;
        if ((gather_rdy & mask) != '0) begin
            flag_mismatch($sformatf("gather_rdy %b high the cycle after acceptance", gather_rdy));
        end
    endtask

    task automatic wait_done(input int limit);
        int cycles;
        cycles = 0;
        while (!all_arrived() && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!all_arrived()) begin
            err_cnt++;
            $display("Timeout after %0d cycles waiting for responses and deallocations", limit);
        end
        // Room for anything unexpected to show up
        repeat (10) @(negedge clk);
    endtask

    task automatic check_results(input bit ordered);
        int hits;
        for (int c = 0; c < CONTEXTS; c++) begin
            chk_cnt++;
            if (got_cnt[c] != exp_cnt[c]) begin
                flag_mismatch($sformatf("context %0d got %0d responses, expected %0d",
                                        c, got_cnt[c], exp_cnt[c]));
            end
            for (int i = 0; i < exp_cnt[c] && i < got_cnt[c]; i++) begin
                chk_cnt++;
                if (got_resp[c][i] != exp_resp[c][i]) begin
                    flag_mismatch($sformatf("context %0d response %0d is %h, expected %h",
                                            c, i, got_resp[c][i], exp_resp[c][i]));
                end
            end
            chk_cnt++;
            if (!gather_rdy[c]) begin
                flag_mismatch($sformatf("context %0d not ready after its chain", c));
            end
        end
        chk_cnt++;
        if (got_dealloc_cnt != exp_dealloc_cnt) begin
            flag_mismatch($sformatf("%0d deallocations, expected %0d",
                                    got_dealloc_cnt, exp_dealloc_cnt));
        end
        for (int i = 0; i < exp_dealloc_cnt; i++) begin
            hits = 0;
            for (int j = 0; j < got_dealloc_cnt; j++) begin
                if (got_dealloc[j] == exp_dealloc[i]) begin
                    hits++;
                end
            end
            chk_cnt++;
            if (hits != 1) begin
                flag_mismatch($sformatf("pointer %h deallocated %0d times", exp_dealloc[i], hits));
            end
            if (ordered && i < got_dealloc_cnt) begin
                chk_cnt++;
                if (got_dealloc[i] != exp_dealloc[i]) begin
                    flag_mismatch($sformatf("deallocation %0d is %h, expected %h",
                                            i, got_dealloc[i], exp_dealloc[i]));
                end
            end
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_single();
        clear_model();
        build_chain(0, 1);
        request_gather(4'b0001);
        wait_done(WAIT_LIMIT);
        check_results(1'b1);
    endtask

    task automatic test_chain();
        clear_model();
        build_chain(1, 5);
        request_gather(4'b0010);
        wait_done(WAIT_LIMIT);
        check_results(1'b1);
    endtask

    // Lengths 2 to 5 started on the same cycle
    task automatic test_concurrent();
        clear_model();
        for (int c = 0; c < CONTEXTS; c++) begin
            build_chain(c, c + 2);
        end
        request_gather('1);
        wait_done(WAIT_LIMIT);
        check_results(1'b0);
    endtask

    task automatic test_enable();
        clear_model();
        build_chain(2, 3);
        @(negedge clk);
        en = 1'b0;
        request_gather(4'b0100);
        repeat (50) @(negedge clk);
        chk_cnt++;
        if (got_cnt[2] != 0 || got_dealloc_cnt != 0) begin
            flag_mismatch("responses or deallocations appeared while en was low");
        end
        en = 1'b1;
        wait_done(WAIT_LIMIT);
        check_results(1'b1);
    endtask

    task automatic test_backpressure();
        int cycles;
        clear_model();
        build_chain(3, 6);
        @(negedge clk);
        gather_ack  = '0;
        dealloc_rdy = 1'b0;
        request_gather(4'b1000);
        cycles = 0;
        while (!gather_rdy[3] && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!gather_rdy[3]) begin
            err_cnt++;
            $display("Timeout waiting for the chain to be read under back-pressure");
        end
        chk_cnt++;
        if (!gather_vld[3] || !dealloc_req) begin
            flag_mismatch("queues empty although the chain was read");
        end
        // Queue heads hold the first buffer while nothing is popped
        chk_cnt++;
        if (gather_resp[3] != exp_resp[3][0]) begin
            flag_mismatch($sformatf("held response is %h, expected %h",
                                    gather_resp[3], exp_resp[3][0]));
        end
        chk_cnt++;
        if (dealloc_ptr != exp_dealloc[0]) begin
            flag_mismatch($sformatf("held deallocation is %h, expected %h",
                                    dealloc_ptr, exp_dealloc[0]));
        end
        gather_ack  = '1;
        dealloc_rdy = 1'b1;
        wait_done(WAIT_LIMIT);
        check_results(1'b1);
    endtask

    task automatic test_ready_rule();
        ptr_t stray;
        clear_model();
        build_chain(0, 4);
        stray = scatter_ptr(alloc_idx);
        request_gather(4'b0001);
        // Retry with another head while the chain is still running
        gather_ptr[0] = stray;
        gather_req[0] = 1'b1;
        repeat (3) begin
            chk_cnt++;
            if (gather_rdy[0]) begin
                flag_mismatch("context 0 ready again while its chain was in progress");
            end
            @(negedge clk);
        end
        gather_req[0] = 1'b0;
        wait_done(WAIT_LIMIT);
        check_results(1'b1);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int assert_fails;
        clk          = 1'b0;
        srst         = 1'b1;
        en           = 1'b1;
        gather_req   = '0;
        gather_ptr   = '0;
        gather_ack   = '1;
        dealloc_rdy  = 1'b1;
        desc_wr      = 1'b0;
        desc_wr_data = '0;
        rng_state    = 32'h0a9092f0;
        alloc_idx    = 0;
        err_cnt      = 0;
        chk_cnt      = 0;
        clear_model();
        repeat (RESET_CYCLES) @(negedge clk);
        srst = 1'b0;
        // Descriptor memory clears itself one entry per cycle
        repeat (INIT_CYCLES) @(negedge clk);

        test_single();
        test_chain();
        test_concurrent();
        test_enable();
        test_backpressure();
        test_ready_rule();

        assert_fails = UUT.i_alloc_gather_core.i_assertions.fail_cnt;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 chk_cnt, err_cnt, assert_fails);
        if (err_cnt == 0 && assert_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb_alloc_gather

// File: files.f
alloc_pkg.sv
desc_mem_pkg.sv
fifo_ctxt.sv
arb_rr.sv
desc_mem.sv
alloc_gather_core.sv
alloc_gather_top.sv
tb_alloc_gather_assertions.sv
tb_alloc_gather.sv
